// File: hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int OPC_W      = 7;
    localparam int CTRL_W     = 2;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [OPC_W-1:0]      opcode_t;
    typedef logic [2:0]            fun3_t;
    typedef logic [6:0]            fun7_t;

    // Major opcodes in instr[6:0]
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;

    localparam fun7_t FUN7_BASE = 7'b0000000;
    localparam fun7_t FUN7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    // Nine formats, so four bits
    typedef enum logic [3:0] {
        FMT_R,
        FMT_I,
        FMT_SYS,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_FENCE,
        FMT_UNKNOWN
    } inst_fmt_e;

    typedef enum logic [5:0] {
        INST_ADD, INST_SUB, INST_SLL, INST_SLT, INST_SLTU,
        INST_XOR, INST_SRL, INST_SRA, INST_OR, INST_AND,
        INST_ADDI, INST_SLTI, INST_SLTIU, INST_XORI, INST_ORI,
        INST_ANDI, INST_SLLI, INST_SRLI, INST_SRAI,
        INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU,
        INST_JALR,
        INST_SB, INST_SH, INST_SW,
        INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
        INST_LUI, INST_AUIPC, INST_JAL,
        INST_ECALL, INST_EBREAK,
        INST_CSRRW, INST_CSRRS, INST_CSRRC,
        INST_CSRRWI, INST_CSRRSI, INST_CSRRCI,
        INST_FENCE, INST_FENCEI,
        INST_UNKNOWN
    } inst_id_e;

    typedef logic [0:0] cfg_addr_t;

    localparam cfg_addr_t CFG_CTRL   = 1'b0;
    localparam cfg_addr_t CFG_ILLCNT = 1'b1;

    localparam int CTRL_CSR_BIT    = 0;
    localparam int CTRL_FENCEI_BIT = 1;

    typedef struct packed {
        inst_fmt_e fmt;
        inst_id_e  id;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        fun3_t     fun3;
        fun7_t     fun7;
        csr_addr_t csr;
        word_t     imm;
    } decoded_t;

    typedef struct packed {
        decoded_t dec;
        word_t    rs1_val;
        word_t    rs2_val;
    } stage_out_t;

endpackage

// File: hdl/rv_inst_decoder.sv
`timescale 1ns/1ps

module rv_inst_decoder (
    input  rv_decode_pkg::word_t    instr_i,
    input  logic                    csr_en_i,
    input  logic                    fencei_en_i,
    output rv_decode_pkg::decoded_t dec_o
);

    rv_decode_pkg::opcode_t  opcode;
    rv_decode_pkg::fun3_t    fun3;
    rv_decode_pkg::fun7_t    fun7;
    rv_decode_pkg::word_t    imm_i;
    rv_decode_pkg::word_t    imm_s;
    rv_decode_pkg::word_t    imm_b;
    rv_decode_pkg::word_t    imm_u;
    rv_decode_pkg::word_t    imm_j;
    rv_decode_pkg::decoded_t fields;
    rv_decode_pkg::inst_id_e id;

    assign opcode = instr_i[6:0];
    assign fun3   = instr_i[14:12];
    assign fun7   = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // Field extraction by format
    always_comb begin
        fields     = '0;
        fields.fmt = rv_decode_pkg::FMT_UNKNOWN;
        case (opcode)
            rv_decode_pkg::OPC_OP: begin
                fields.fmt  = rv_decode_pkg::FMT_R;
                fields.rd   = instr_i[11:7];
                fields.fun3 = fun3;
                fields.rs1  = instr_i[19:15];
                fields.rs2  = instr_i[24:20];
                fields.fun7 = fun7;
            end
            rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_LOAD, rv_decode_pkg::OPC_JALR: begin
                fields.fmt  = rv_decode_pkg::FMT_I;
                fields.rd   = instr_i[11:7];
                fields.fun3 = fun3;
                fields.rs1  = instr_i[19:15];
                fields.imm  = imm_i;
                if ((opcode == rv_decode_pkg::OPC_OP_IMM) && (fun3[1:0] == 2'b01)) begin
                    fields.fun7 = fun7;  // Shift type lives in fun7
                end
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                fields.fmt  = rv_decode_pkg::FMT_SYS;
                fields.rd   = instr_i[11:7];
                fields.fun3 = fun3;
                fields.rs1  = instr_i[19:15];  // uimm for the CSR*I forms
                fields.csr  = instr_i[31:20];
                fields.imm  = imm_i;
            end
            rv_decode_pkg::OPC_STORE: begin
                fields.fmt  = rv_decode_pkg::FMT_S;
                fields.fun3 = fun3;
                fields.rs1  = instr_i[19:15];
                fields.rs2  = instr_i[24:20];
                fields.imm  = imm_s;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                fields.fmt  = rv_decode_pkg::FMT_B;
                fields.fun3 = fun3;
                fields.rs1  = instr_i[19:15];
                fields.rs2  = instr_i[24:20];
                fields.imm  = imm_b;
            end
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
                fields.fmt = rv_decode_pkg::FMT_U;
                fields.rd  = instr_i[11:7];
                fields.imm = imm_u;
            end
            rv_decode_pkg::OPC_JAL: begin
                fields.fmt = rv_decode_pkg::FMT_J;
                fields.rd  = instr_i[11:7];
                fields.imm = imm_j;
            end
            rv_decode_pkg::OPC_MISC_MEM: begin
                fields.fmt  = rv_decode_pkg::FMT_FENCE;
                fields.rd   = instr_i[11:7];
                fields.fun3 = fun3;
                fields.rs1  = instr_i[19:15];
                fields.imm  = imm_i;  // fm, pred, succ
            end
            default: begin
                fields.fmt = rv_decode_pkg::FMT_UNKNOWN;
            end
        endcase
    end

    // Instruction identification
    always_comb begin
        id = rv_decode_pkg::INST_UNKNOWN;
        case (opcode)
            rv_decode_pkg::OPC_OP: begin
                case ({fun7, fun3})
                    {rv_decode_pkg::FUN7_BASE, 3'b000}: id = rv_decode_pkg::INST_ADD;
                    {rv_decode_pkg::FUN7_ALT,  3'b000}: id = rv_decode_pkg::INST_SUB;
                    {rv_decode_pkg::FUN7_BASE, 3'b001}: id = rv_decode_pkg::INST_SLL;
                    {rv_decode_pkg::FUN7_BASE, 3'b010}: id = rv_decode_pkg::INST_SLT;
                    {rv_decode_pkg::FUN7_BASE, 3'b011}: id = rv_decode_pkg::INST_SLTU;
                    {rv_decode_pkg::FUN7_BASE, 3'b100}: id = rv_decode_pkg::INST_XOR;
                    {rv_decode_pkg::FUN7_BASE, 3'b101}: id = rv_decode_pkg::INST_SRL;
                    {rv_decode_pkg::FUN7_ALT,  3'b101}: id = rv_decode_pkg::INST_SRA;
                    {rv_decode_pkg::FUN7_BASE, 3'b110}: id = rv_decode_pkg::INST_OR;
                    {rv_decode_pkg::FUN7_BASE, 3'b111}: id = rv_decode_pkg::INST_AND;
                    default:                            id = rv_decode_pkg::INST_UNKNOWN;
                endcase
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                case (fun3)
                    3'b000: id = rv_decode_pkg::INST_ADDI;
                    3'b010: id = rv_decode_pkg::INST_SLTI;
                    3'b011: id = rv_decode_pkg::INST_SLTIU;
                    3'b100: id = rv_decode_pkg::INST_XORI;
                    3'b110: id = rv_decode_pkg::INST_ORI;
                    3'b111: id = rv_decode_pkg::INST_ANDI;
                    3'b001: begin
                        if (fun7 == rv_decode_pkg::FUN7_BASE) begin
                            id = rv_decode_pkg::INST_SLLI;
                        end
                    end
                    default: begin  // 3'b101
                        if (fun7 == rv_decode_pkg::FUN7_BASE) begin
                            id = rv_decode_pkg::INST_SRLI;
                        end else if (fun7 == rv_decode_pkg::FUN7_ALT) begin
                            id = rv_decode_pkg::INST_SRAI;
                        end
                    end
                endcase
            end
            rv_decode_pkg::OPC_LOAD: begin
                case (fun3)
                    3'b000:  id = rv_decode_pkg::INST_LB;
                    3'b001:  id = rv_decode_pkg::INST_LH;
                    3'b010:  id = rv_decode_pkg::INST_LW;
                    3'b100:  id = rv_decode_pkg::INST_LBU;
                    3'b101:  id = rv_decode_pkg::INST_LHU;
                    default: id = rv_decode_pkg::INST_UNKNOWN;
                endcase
            end
            rv_decode_pkg::OPC_JALR: begin
                if (fun3 == 3'b000) begin
                    id = rv_decode_pkg::INST_JALR;
                end
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                if (csr_en_i) begin
                    case (fun3)
                        3'b000:  id = instr_i[20] ? rv_decode_pkg::INST_EBREAK
                                                  : rv_decode_pkg::INST_ECALL;
                        3'b001:  id = rv_decode_pkg::INST_CSRRW;
                        3'b010:  id = rv_decode_pkg::INST_CSRRS;
                        3'b011:  id = rv_decode_pkg::INST_CSRRC;
                        3'b101:  id = rv_decode_pkg::INST_CSRRWI;
                        3'b110:  id = rv_decode_pkg::INST_CSRRSI;
                        3'b111:  id = rv_decode_pkg::INST_CSRRCI;
                        default: id = rv_decode_pkg::INST_UNKNOWN;
                    endcase
                end
            end
            rv_decode_pkg::OPC_STORE: begin
                case (fun3)
                    3'b000:  id = rv_decode_pkg::INST_SB;
                    3'b001:  id = rv_decode_pkg::INST_SH;
                    3'b010:  id = rv_decode_pkg::INST_SW;
                    default: id = rv_decode_pkg::INST_UNKNOWN;
                endcase
            end
            rv_decode_pkg::OPC_BRANCH: begin
                case (fun3)
                    3'b000:  id = rv_decode_pkg::INST_BEQ;
                    3'b001:  id = rv_decode_pkg::INST_BNE;
                    3'b100:  id = rv_decode_pkg::INST_BLT;
                    3'b101:  id = rv_decode_pkg::INST_BGE;
                    3'b110:  id = rv_decode_pkg::INST_BLTU;
                    3'b111:  id = rv_decode_pkg::INST_BGEU;
                    default: id = rv_decode_pkg::INST_UNKNOWN;
                endcase
            end
            rv_decode_pkg::OPC_LUI:   id = rv_decode_pkg::INST_LUI;
            rv_decode_pkg::OPC_AUIPC: id = rv_decode_pkg::INST_AUIPC;
            rv_decode_pkg::OPC_JAL:   id = rv_decode_pkg::INST_JAL;
            rv_decode_pkg::OPC_MISC_MEM: begin
                if (fun3 == 3'b000) begin
                    id = rv_decode_pkg::INST_FENCE;
                end else if ((fun3 == 3'b001) && fencei_en_i) begin
                    id = rv_decode_pkg::INST_FENCEI;
                end
            end
            default: id = rv_decode_pkg::INST_UNKNOWN;
        endcase
    end

    // Unknown encodings leave no stray fields behind
    always_comb begin
        dec_o    = fields;
        dec_o.id = id;
        if (id == rv_decode_pkg::INST_UNKNOWN) begin
            dec_o     = '0;
            dec_o.fmt = rv_decode_pkg::FMT_UNKNOWN;
            dec_o.id  = rv_decode_pkg::INST_UNKNOWN;
        end
    end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                     i_clk,
    input  logic                     rst_i,
    input  logic                     we_i,
    input  rv_decode_pkg::reg_idx_t  waddr_i,
    input  rv_decode_pkg::word_t     wdata_i,
    input  rv_decode_pkg::reg_idx_t  raddr1_i,
    input  rv_decode_pkg::reg_idx_t  raddr2_i,
    output rv_decode_pkg::word_t     rdata1_o,
    output rv_decode_pkg::word_t     rdata2_o
);

    localparam int NUM_REGS = 2 ** rv_decode_pkg::REG_ADDR_W;

    rv_decode_pkg::word_t regs_q [NUM_REGS-1:1];  // x0 has no storage

    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle read sees the old value as there is no write bypass
    always_comb begin
        rdata1_o = '0;
        rdata2_o = '0;
        if (raddr1_i != '0) begin
            rdata1_o = regs_q[raddr1_i];
        end
        if (raddr2_i != '0) begin
            rdata2_o = regs_q[raddr2_i];
        end
    end

endmodule

// File: hdl/rv_decode_cfg.sv
`timescale 1ns/1ps

module rv_decode_cfg (
    input  logic                     i_clk,
    input  logic                     rst_i,
    input  logic                     we_i,
    input  rv_decode_pkg::cfg_addr_t addr_i,
    input  rv_decode_pkg::word_t     wdata_i,
    output rv_decode_pkg::word_t     rdata_o,
    input  logic                     inst_valid_i,
    input  rv_decode_pkg::inst_id_e  inst_id_i,
    output logic                     csr_en_o,
    output logic                     fencei_en_o
);

    logic [rv_decode_pkg::CTRL_W-1:0] ctrl_q;
    rv_decode_pkg::word_t             illcnt_q;
    logic                             ill_hit;
    logic                             cnt_clr;

    assign ill_hit = inst_valid_i && (inst_id_i == rv_decode_pkg::INST_UNKNOWN);
    assign cnt_clr = we_i && (addr_i == rv_decode_pkg::CFG_ILLCNT);  // Data ignored

    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            ctrl_q <= '1;  // Both enables on
        end else if (we_i && (addr_i == rv_decode_pkg::CFG_CTRL)) begin
            ctrl_q <= wdata_i[rv_decode_pkg::CTRL_W-1:0];
        end
    end

    // Clear wins over a same-cycle increment
    always_ff @(posedge i_clk) begin
        if (rst_i || cnt_clr) begin
            illcnt_q <= '0;
        end else if (ill_hit && (illcnt_q != '1)) begin
            illcnt_q <= illcnt_q + 1'b1;
        end
    end

    assign csr_en_o    = ctrl_q[rv_decode_pkg::CTRL_CSR_BIT];
    assign fencei_en_o = ctrl_q[rv_decode_pkg::CTRL_FENCEI_BIT];

    assign rdata_o = (addr_i == rv_decode_pkg::CFG_ILLCNT) ? illcnt_q
                   : {{(rv_decode_pkg::XLEN - rv_decode_pkg::CTRL_W){1'b0}}, ctrl_q};

endmodule

// File: hdl/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage (
    input  logic                      i_clk,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  rv_decode_pkg::word_t      instr_i,
    input  logic                      wb_en_i,
    input  rv_decode_pkg::reg_idx_t   wb_rd_i,
    input  rv_decode_pkg::word_t      wb_data_i,
    input  logic                      cfg_we_i,
    input  rv_decode_pkg::cfg_addr_t  cfg_addr_i,
    input  rv_decode_pkg::word_t      cfg_wdata_i,
    output rv_decode_pkg::word_t      cfg_rdata_o,
    output logic                      valid_o,
    output rv_decode_pkg::stage_out_t stage_o
);

    rv_decode_pkg::decoded_t   dec;
    rv_decode_pkg::word_t      rs1_val;
    rv_decode_pkg::word_t      rs2_val;
    logic                      csr_en;
    logic                      fencei_en;
    rv_decode_pkg::stage_out_t stage_d;
    rv_decode_pkg::stage_out_t stage_q;
    logic                      valid_q;

    rv_inst_decoder u_decoder (
        .instr_i     (instr_i),
        .csr_en_i    (csr_en),
        .fencei_en_i (fencei_en),
        .dec_o       (dec)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .rst_i    (rst_i),
        .we_i     (wb_en_i),
        .waddr_i  (wb_rd_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (dec.rs1),
        .raddr2_i (dec.rs2),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val)
    );

    rv_decode_cfg u_cfg (
        .i_clk        (i_clk),
        .rst_i        (rst_i),
        .we_i         (cfg_we_i),
        .addr_i       (cfg_addr_i),
        .wdata_i      (cfg_wdata_i),
        .rdata_o      (cfg_rdata_o),
        .inst_valid_i (valid_i),
        .inst_id_i    (dec.id),
        .csr_en_o     (csr_en),
        .fencei_en_o  (fencei_en)
    );

    assign stage_d = '{dec: dec, rs1_val: rs1_val, rs2_val: rs2_val};

    // One-cycle output register that holds its payload while idle
    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            stage_q <= '0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                stage_q <= stage_d;
            end
        end
    end

    assign valid_o = valid_q;
    assign stage_o = stage_q;

endmodule

// File: verif/tb_rv_decode_stage.sv
`timescale 1ns/1ps

module tb_rv_decode_stage;

    localparam int    CLK_PERIOD = 100;
    localparam int    N_RAND     = 40;  // Each one is a write plus an ADD
    localparam string VEC_FILE   = "verif/rv_decode_vectors.txt";

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    rv_decode_pkg::word_t      instr;
    logic                      wb_en;
    rv_decode_pkg::reg_idx_t   wb_rd;
    rv_decode_pkg::word_t      wb_data;
    logic                      cfg_we;
    rv_decode_pkg::cfg_addr_t  cfg_addr;
    rv_decode_pkg::word_t      cfg_wdata;
    rv_decode_pkg::word_t      cfg_rdata;
    logic                      out_valid;
    rv_decode_pkg::stage_out_t stage;

    string                     lines [$];
    rv_decode_pkg::word_t      model [32];  // Architectural register contents
    rv_decode_pkg::stage_out_t exp_now;     // Driven this cycle
    rv_decode_pkg::stage_out_t exp_out;     // Due on stage_o this cycle
    logic                      now_vld;
    logic                      out_vld;
    logic                      rd_chk;
    rv_decode_pkg::word_t      rd_exp;
    logic [31:0]               rng;
    logic                      loaded = 1'b0;
    int                        err_cnt;
    int                        file_errs;
    int                        n_checks;

    rv_decode_stage UUT (
        .i_clk       (clk),
        .rst_i       (rst),
        .valid_i     (in_valid),
        .instr_i     (instr),
        .wb_en_i     (wb_en),
        .wb_rd_i     (wb_rd),
        .wb_data_i   (wb_data),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata),
        .valid_o     (out_valid),
        .stage_o     (stage)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Enum names in the vector file map to their codes
    function automatic int fmt_code(input string s);
        rv_decode_pkg::inst_fmt_e f;
        for (int i = 0; i < 16; i++) begin
            f = rv_decode_pkg::inst_fmt_e'(i);
            if (f.name() == s) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int id_code(input string s);
        rv_decode_pkg::inst_id_e e;
        for (int i = 0; i < 64; i++) begin
            e = rv_decode_pkg::inst_id_e'(i);
            if (e.name() == s) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic start_step();
        @(posedge clk);
        in_valid <= 1'b0;
        wb_en    <= 1'b0;
        cfg_we   <= 1'b0;
    endtask

    task automatic finish_step();
        @(negedge clk);
        check_val("valid_o", out_valid, out_vld);
        if (out_vld) begin
            check_val("fmt", stage.dec.fmt, exp_out.dec.fmt);
            check_val("id", stage.dec.id, exp_out.dec.id);
            check_val("rd", stage.dec.rd, exp_out.dec.rd);
            check_val("rs1", stage.dec.rs1, exp_out.dec.rs1);
            check_val("rs2", stage.dec.rs2, exp_out.dec.rs2);
            check_val("fun3", stage.dec.fun3, exp_out.dec.fun3);
            check_val("fun7", stage.dec.fun7, exp_out.dec.fun7);
            check_val("csr", stage.dec.csr, exp_out.dec.csr);
            check_val("imm", stage.dec.imm, exp_out.dec.imm);
            check_val("rs1_val", stage.rs1_val, exp_out.rs1_val);
            check_val("rs2_val", stage.rs2_val, exp_out.rs2_val);
        end else begin
            check_val("held id", stage.dec.id, exp_out.dec.id);
        end
        if (rd_chk) begin
            check_val("cfg_rdata", cfg_rdata, rd_exp);
        end
        rd_chk  = 1'b0;
        out_vld = now_vld;
        if (now_vld) begin
            exp_out = exp_now;
        end
        now_vld = 1'b0;
    endtask

    task automatic expect_instr(input rv_decode_pkg::word_t ins, input int fmt, input int id,
                                input rv_decode_pkg::reg_idx_t rd,
                                input rv_decode_pkg::reg_idx_t rs1,
                                input rv_decode_pkg::reg_idx_t rs2,
                                input rv_decode_pkg::word_t imm, input rv_decode_pkg::word_t v1,
                                input rv_decode_pkg::word_t v2);
        in_valid        <= 1'b1;
        instr           <= ins;
        exp_now         = '0;
        exp_now.dec.fmt = rv_decode_pkg::inst_fmt_e'(fmt);
        exp_now.dec.id  = rv_decode_pkg::inst_id_e'(id);
        exp_now.dec.rd  = rd;
        exp_now.dec.rs1 = rs1;
        exp_now.dec.rs2 = rs2;
        exp_now.dec.imm = imm;
        exp_now.rs1_val = v1;
        exp_now.rs2_val = v2;
        if ((exp_now.dec.fmt != rv_decode_pkg::FMT_U) &&
            (exp_now.dec.fmt != rv_decode_pkg::FMT_J) &&
            (exp_now.dec.fmt != rv_decode_pkg::FMT_UNKNOWN)) begin
            exp_now.dec.fun3 = ins[14:12];
        end
        // fun7 survives in R type and in the OP-IMM shifts only
        if ((exp_now.dec.fmt == rv_decode_pkg::FMT_R) ||
            ((exp_now.dec.fmt == rv_decode_pkg::FMT_I) && (ins[6:0] == 7'b0010011) &&
             (ins[13:12] == 2'b01))) begin
            exp_now.dec.fun7 = ins[31:25];
        end
        if (exp_now.dec.fmt == rv_decode_pkg::FMT_SYS) begin
            exp_now.dec.csr = ins[31:20];
        end
        now_vld         = 1'b1;
    endtask

    task automatic write_reg(input rv_decode_pkg::reg_idx_t idx, input rv_decode_pkg::word_t data);
        wb_en   <= 1'b1;
        wb_rd   <= idx;
        wb_data <= data;
        if (idx != 0) begin
            model[idx] = data;  // x0 stays zero
        end
    endtask

    task automatic run_line(input string line);
        string       cmd;
        string       fs;
        string       ids;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] v1;
        logic [31:0] v2;
        int          rd;
        int          rs1;
        int          rs2;
        int          n;
        bit          ok;
        start_step();
        n  = $sscanf(line, "%s", cmd);
        ok = (n == 1);
        if (cmd == "W") begin
            ok = ($sscanf(line, "%s %h %h", cmd, a, b) == 3);
            if (ok) begin
                write_reg(a[4:0], b);
            end
        end else if (cmd == "C") begin
            ok = ($sscanf(line, "%s %h %h", cmd, a, b) == 3);
            if (ok) begin
                cfg_we    <= 1'b1;
                cfg_addr  <= a[0];
                cfg_wdata <= b;
            end
        end else if (cmd == "R") begin
            ok = ($sscanf(line, "%s %h %h", cmd, a, b) == 3);
            if (ok) begin
                cfg_addr <= a[0];
                rd_chk   = 1'b1;
                rd_exp   = b;
            end
        end else if (cmd == "I") begin
            n  = $sscanf(line, "%s %h %s %s %d %d %d %h %h %h",
                         cmd, a, fs, ids, rd, rs1, rs2, imm, v1, v2);
            ok = (n == 10) && (fmt_code(fs) >= 0) && (id_code(ids) >= 0);
            if (ok) begin
                expect_instr(a, fmt_code(fs), id_code(ids), rd[4:0], rs1[4:0], rs2[4:0],
                             imm, v1, v2);
            end
        end else if (cmd != "N") begin
            ok = 1'b0;
        end
        if (!ok) begin
            file_errs++;
            $display("Could not read the vector line: %s", line);
        end
        finish_step();
    endtask

    task automatic random_add();
        rv_decode_pkg::reg_idx_t rd;
        rv_decode_pkg::reg_idx_t rs1;
        rv_decode_pkg::reg_idx_t rs2;
        rng = xorshift(rng);
        start_step();
        write_reg(rng[4:0], xorshift(rng ^ 32'h5a5a_0f0f));
        finish_step();
        rng = xorshift(rng);
        rd  = rng[4:0];
        rs1 = rng[12:8];
        rs2 = rng[20:16];
        start_step();
        expect_instr({7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011}, fmt_code("FMT_R"),
                     id_code("INST_ADD"), rd, rs1, rs2, '0, model[rs1], model[rs2]);
        finish_step();
    endtask

    initial begin
        int    fd;
        string line;
        rst       = 1'b1;
        in_valid  = 1'b0;
        instr     = '0;
        wb_en     = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        now_vld   = 1'b0;
        out_vld   = 1'b0;
        rd_chk    = 1'b0;
        rd_exp    = '0;
        exp_now   = '0;
        exp_out   = '0;  // Matches the reset value of stage_o
        err_cnt   = 0;
        file_errs = 0;
        n_checks  = 0;
        rng       = 32'he77b;
        foreach (model[i]) begin
            model[i] = '0;
        end
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            file_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    if ((line[0] != "#") && (line[0] != "\n")) begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        repeat (N_RAND) begin
            random_add();
        end
        repeat (2) begin  // Drain the last instruction and one idle cycle
            start_step();
            finish_step();
        end
        $display("Checks: %0d, value errors: %0d, file errors: %0d",
                 n_checks, err_cnt, file_errs);
        if ((err_cnt == 0) && (file_errs == 0) && (n_checks > 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #(CLK_PERIOD * (lines.size() + 2 * N_RAND + 50));
        $display("Timeout: the run did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verif/rv_decode_vectors.txt
# W rd data | C addr data | R addr expected | N idle cycle
# I instr fmt id rd rs1 rs2 imm rs1_val rs2_val (indices decimal, the rest hex)
R 1 00000000
R 0 00000003
W 1 00000005
W 2 fffffff0
W 0 deadbeef
N
I 002081b3 FMT_R INST_ADD 3 1 2 00000000 00000005 fffffff0
I 40208233 FMT_R INST_SUB 4 1 2 00000000 00000005 fffffff0
I 001002b3 FMT_R INST_ADD 5 0 1 00000000 00000000 00000005
I fff08313 FMT_I INST_ADDI 6 1 0 ffffffff 00000005 00000000
I 40315393 FMT_I INST_SRAI 7 2 0 00000403 fffffff0 00000000
I 00315393 FMT_I INST_SRLI 7 2 0 00000003 fffffff0 00000000
I ffc0a403 FMT_I INST_LW 8 1 0 fffffffc 00000005 00000000
I fe20ac23 FMT_S INST_SW 0 1 2 fffffff8 00000005 fffffff0
I fe2098e3 FMT_B INST_BNE 0 1 2 fffffff0 00000005 fffffff0
N
I 123454b7 FMT_U INST_LUI 9 0 0 12345000 00000000 00000000
I fffff517 FMT_U INST_AUIPC 10 0 0 fffff000 00000000 00000000
I ffdff0ef FMT_J INST_JAL 1 0 0 fffffffc 00000000 00000000
I 0ff0000f FMT_FENCE INST_FENCE 0 0 0 000000ff 00000000 00000000
I 0000100f FMT_FENCE INST_FENCEI 0 0 0 00000000 00000000 00000000
I 00000073 FMT_SYS INST_ECALL 0 0 0 00000000 00000000 00000000
I 00100073 FMT_SYS INST_EBREAK 0 0 0 00000001 00000000 00000000
I 340095f3 FMT_SYS INST_CSRRW 11 1 0 00000340 00000005 00000000
I 022081b3 FMT_UNKNOWN INST_UNKNOWN 0 0 0 00000000 00000000 00000000
I ffffffff FMT_UNKNOWN INST_UNKNOWN 0 0 0 00000000 00000000 00000000
R 1 00000002
C 1 00000000
R 1 00000000
C 0 00000000
R 0 00000000
I 340095f3 FMT_UNKNOWN INST_UNKNOWN 0 0 0 00000000 00000000 00000000
I 0000100f FMT_UNKNOWN INST_UNKNOWN 0 0 0 00000000 00000000 00000000
R 1 00000002
C 0 00000003
I 340095f3 FMT_SYS INST_CSRRW 11 1 0 00000340 00000005 00000000
I 0000100f FMT_FENCE INST_FENCEI 0 0 0 00000000 00000000 00000000
N
R 1 00000002

// File: list.f
hdl/rv_decode_pkg.sv
hdl/rv_inst_decoder.sv
hdl/rv_regfile.sv
hdl/rv_decode_cfg.sv
hdl/rv_decode_stage.sv
verif/tb_rv_decode_stage.sv

// File: Bender.yml
package:
  name: rv_decode_stage

sources:
  - hdl/rv_decode_pkg.sv
  - hdl/rv_inst_decoder.sv
  - hdl/rv_regfile.sv
  - hdl/rv_decode_cfg.sv
  - hdl/rv_decode_stage.sv
  - target: test
    files:
      - verif/tb_rv_decode_stage.sv
